//--- design/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // ########################################################################
    // widths and address map
    // ########################################################################

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [31:0]     addr_t;

    // bit 31 set means mmio.
    localparam addr_t MMIO_BASE = 32'h8000_0000;

    // ########################################################################
    // enums
    // ########################################################################

    // word slot inside the mmio region, byte offset is value * 4.
    typedef enum logic [2:0] {
        REG_MCYCLE_LO   = 3'd0,
        REG_MCYCLE_HI   = 3'd1,
        REG_MTIME_LO    = 3'd2,
        REG_MTIME_HI    = 3'd3,
        REG_MTIMECMP_LO = 3'd4,
        REG_MTIMECMP_HI = 3'd5,
        REG_EXIT        = 3'd6,
        REG_NONE        = 3'd7
    } mmio_reg_e;

    // who holds the memory port.
    typedef enum logic [1:0] {
        OWN_IDLE = 2'd0,
        OWN_INST = 2'd1,
        OWN_DATA = 2'd2
    } bus_owner_e;

endpackage

`default_nettype wire

//--- design/main_memory.sv
`timescale 1ns/1ps
`default_nettype none

module main_memory #(
    parameter int MEM_WORDS_LOG2 = 10
) (
    input  wire                     clk_in,
    input  wire                     rst_n,
    input  wire                     req_valid,
    output logic                    req_ready,
    input  wire soc_pkg::addr_t     req_addr,
    input  wire                     req_wen,
    input  wire soc_pkg::data_t     req_wdata,
    output logic                    resp_valid,
    output soc_pkg::data_t          resp_rdata
);

    soc_pkg::data_t mem [0:(1 << MEM_WORDS_LOG2) - 1];

    logic [MEM_WORDS_LOG2-1:0] word_idx;

    // no file load, memory comes up cleared.
    initial begin
        for (int i = 0; i < (1 << MEM_WORDS_LOG2); i++) begin
            mem[i] = '0;
        end
    end

    assign req_ready = 1'b1;
    assign word_idx  = req_addr[MEM_WORDS_LOG2+1:2];

    // read sees the old word, writes ack with zero.
    always_ff @(posedge clk_in) begin
        if (req_valid && req_ready) begin
            if (req_wen) begin
                mem[word_idx] <= req_wdata;
            end
            resp_rdata <= req_wen ? '0 : mem[word_idx];
        end
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_valid && req_ready;
        end
    end

endmodule

`default_nettype wire

//--- design/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire                 clk_in,
    input  wire                 rst_n,

    input  wire                 ireq_valid,
    output logic                ireq_ready,
    input  wire soc_pkg::addr_t ireq_addr,
    output logic                iresp_valid,
    output soc_pkg::data_t      iresp_rdata,

    input  wire                 dreq_valid,
    output logic                dreq_ready,
    input  wire soc_pkg::addr_t dreq_addr,
    input  wire                 dreq_wen,
    input  wire soc_pkg::data_t dreq_wdata,
    output logic                dresp_valid,
    output soc_pkg::data_t      dresp_rdata,

    output logic                mem_req_valid,
    input  wire                 mem_req_ready,
    output soc_pkg::addr_t      mem_req_addr,
    output logic                mem_req_wen,
    output soc_pkg::data_t      mem_req_wdata,
    input  wire                 mem_resp_valid,
    input  wire soc_pkg::data_t mem_resp_rdata
);

    soc_pkg::bus_owner_e owner_q;
    soc_pkg::bus_owner_e owner_d;

    logic idle;

    assign idle = (owner_q == soc_pkg::OWN_IDLE);

    // data wins, inst only gets through when data is quiet.
    assign dreq_ready = idle && mem_req_ready;
    assign ireq_ready = idle && mem_req_ready && !dreq_valid;

    assign mem_req_valid = idle && (dreq_valid || ireq_valid);
    assign mem_req_addr  = dreq_valid ? dreq_addr : ireq_addr;
    assign mem_req_wen   = dreq_valid && dreq_wen;
    assign mem_req_wdata = dreq_wdata;

    // steer the response back to whoever owns the port.
    assign dresp_valid = (owner_q == soc_pkg::OWN_DATA) && mem_resp_valid;
    assign dresp_rdata = mem_resp_rdata;
    assign iresp_valid = (owner_q == soc_pkg::OWN_INST) && mem_resp_valid;
    assign iresp_rdata = mem_resp_rdata;

    always_comb begin
        owner_d = owner_q;
        case (owner_q)
            soc_pkg::OWN_IDLE: begin
                if (dreq_valid && dreq_ready) begin
                    owner_d = soc_pkg::OWN_DATA;
                end else if (ireq_valid && ireq_ready) begin
                    owner_d = soc_pkg::OWN_INST;
                end
            end
            soc_pkg::OWN_INST,
            soc_pkg::OWN_DATA: begin
                if (mem_resp_valid) begin
                    owner_d = soc_pkg::OWN_IDLE;
                end
            end
            default: owner_d = soc_pkg::OWN_IDLE;
        endcase
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            owner_q <= soc_pkg::OWN_IDLE;
        end else begin
            owner_q <= owner_d;
        end
    end

endmodule

`default_nettype wire

//--- design/mmio_router.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_router (
    input  wire                     clk_in,
    input  wire                     rst_n,

    input  wire                     dreq_valid,
    output logic                    dreq_ready,
    input  wire soc_pkg::addr_t     dreq_addr,
    input  wire                     dreq_wen,
    input  wire soc_pkg::data_t     dreq_wdata,
    output logic                    dresp_valid,
    output soc_pkg::data_t          dresp_rdata,

    output logic                    m_req_valid,
    input  wire                     m_req_ready,
    output soc_pkg::addr_t          m_req_addr,
    output logic                    m_req_wen,
    output soc_pkg::data_t          m_req_wdata,
    input  wire                     m_resp_valid,
    input  wire soc_pkg::data_t     m_resp_rdata,

    output logic                    t_req_valid,
    output soc_pkg::mmio_reg_e      t_req_offset,
    output logic                    t_req_wen,
    output soc_pkg::data_t          t_req_wdata,
    input  wire                     t_resp_valid,
    input  wire soc_pkg::data_t     t_resp_rdata
);

    logic           is_mmio;
    logic           pending;
    logic           target_mmio;
    logic           accept;
    soc_pkg::addr_t mmio_off;

    assign is_mmio  = (dreq_addr >= soc_pkg::MMIO_BASE);
    assign mmio_off = dreq_addr - soc_pkg::MMIO_BASE;

    // timer side never stalls.
    assign dreq_ready = !pending && (is_mmio || m_req_ready);
    assign accept     = dreq_valid && dreq_ready;

    assign m_req_valid = dreq_valid && !is_mmio && !pending;
    assign m_req_addr  = dreq_addr;
    assign m_req_wen   = dreq_wen;
    assign m_req_wdata = dreq_wdata;

    assign t_req_valid = dreq_valid && is_mmio && !pending;
    assign t_req_wen   = dreq_wen;
    assign t_req_wdata = dreq_wdata;

    // anything past the last slot lands on REG_NONE.
    always_comb begin
        if (mmio_off[31:5] == '0) begin
            t_req_offset = soc_pkg::mmio_reg_e'(mmio_off[4:2]);
        end else begin
            t_req_offset = soc_pkg::REG_NONE;
        end
    end

    assign dresp_valid = pending && (target_mmio ? t_resp_valid : m_resp_valid);
    assign dresp_rdata = target_mmio ? t_resp_rdata : m_resp_rdata;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            pending     <= 1'b0;
            target_mmio <= 1'b0;
        end else if (accept) begin
            pending     <= 1'b1;
            target_mmio <= is_mmio;
        end else if (dresp_valid) begin
            pending     <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/timer_regs.sv
`timescale 1ns/1ps
`default_nettype none

module timer_regs #(
    parameter int CLK_MHZ = 4
) (
    input  wire                         clk_in,
    input  wire                         rst_n,
    input  wire                         req_valid,
    input  wire soc_pkg::mmio_reg_e     req_offset,
    input  wire                         req_wen,
    input  wire soc_pkg::data_t         req_wdata,
    output logic                        resp_valid,
    output soc_pkg::data_t              resp_rdata,
    output logic                        timer_irq,
    output logic                        exit,
    output soc_pkg::data_t              exit_code
);

    localparam int PW = (CLK_MHZ > 1) ? $clog2(CLK_MHZ) : 1;

    logic [63:0]   mcycle;
    logic [63:0]   mtime;
    logic [63:0]   mtimecmp;
    logic [PW-1:0] presc;
    logic          wr;

    assign wr = req_valid && req_wen;

    // ########################################################################
    // counters
    // ########################################################################

    // mtime ticks once per microsecond.
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            mcycle <= '0;
            mtime  <= '0;
            presc  <= '0;
        end else begin
            mcycle <= mcycle + 64'd1;
            if (presc == PW'(CLK_MHZ - 1)) begin
                presc <= '0;
                mtime <= mtime + 64'd1;
            end else begin
                presc <= presc + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp  <= '1;
            timer_irq <= 1'b0;
        end else begin
            if (wr && req_offset == soc_pkg::REG_MTIMECMP_LO) begin
                mtimecmp[31:0] <= req_wdata;
            end
            if (wr && req_offset == soc_pkg::REG_MTIMECMP_HI) begin
                mtimecmp[63:32] <= req_wdata;
            end
            timer_irq <= (mtime >= mtimecmp);
        end
    end

    // ########################################################################
    // exit and register reads
    // ########################################################################

    // first exit write sticks until reset.
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            exit      <= 1'b0;
            exit_code <= '0;
        end else if (wr && req_offset == soc_pkg::REG_EXIT && !exit) begin
            exit      <= 1'b1;
            exit_code <= req_wdata;
        end
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        if (req_valid) begin
            if (req_wen) begin
                resp_rdata <= '0;
            end else begin
                case (req_offset)
                    soc_pkg::REG_MCYCLE_LO:   resp_rdata <= mcycle[31:0];
                    soc_pkg::REG_MCYCLE_HI:   resp_rdata <= mcycle[63:32];
                    soc_pkg::REG_MTIME_LO:    resp_rdata <= mtime[31:0];
                    soc_pkg::REG_MTIME_HI:    resp_rdata <= mtime[63:32];
                    soc_pkg::REG_MTIMECMP_LO: resp_rdata <= mtimecmp[31:0];
                    soc_pkg::REG_MTIMECMP_HI: resp_rdata <= mtimecmp[63:32];
                    soc_pkg::REG_EXIT:        resp_rdata <= exit_code;
                    default:                  resp_rdata <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- design/mem_sys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sys_top #(
    parameter int MEM_WORDS_LOG2 = 10,
    parameter int CLK_MHZ        = 4
) (
    input  wire                 clk_in,
    input  wire                 rst_n,

    input  wire                 ireq_valid,
    output logic                ireq_ready,
    input  wire soc_pkg::addr_t ireq_addr,
    output logic                iresp_valid,
    output soc_pkg::data_t      iresp_rdata,

    input  wire                 dreq_valid,
    output logic                dreq_ready,
    input  wire soc_pkg::addr_t dreq_addr,
    input  wire                 dreq_wen,
    input  wire soc_pkg::data_t dreq_wdata,
    output logic                dresp_valid,
    output soc_pkg::data_t      dresp_rdata,

    output logic                timer_irq,
    output logic                exit,
    output soc_pkg::data_t      exit_code
);

    // router to arbiter.
    logic               m_req_valid;
    logic               m_req_ready;
    soc_pkg::addr_t     m_req_addr;
    logic               m_req_wen;
    soc_pkg::data_t     m_req_wdata;
    logic               m_resp_valid;
    soc_pkg::data_t     m_resp_rdata;

    // router to timer block.
    logic               t_req_valid;
    soc_pkg::mmio_reg_e t_req_offset;
    logic               t_req_wen;
    soc_pkg::data_t     t_req_wdata;
    logic               t_resp_valid;
    soc_pkg::data_t     t_resp_rdata;

    // arbiter to memory.
    logic               mem_req_valid;
    logic               mem_req_ready;
    soc_pkg::addr_t     mem_req_addr;
    logic               mem_req_wen;
    soc_pkg::data_t     mem_req_wdata;
    logic               mem_resp_valid;
    soc_pkg::data_t     mem_resp_rdata;

    mmio_router router0 (
        .clk_in(clk_in), .rst_n(rst_n),
        .dreq_valid(dreq_valid), .dreq_ready(dreq_ready), .dreq_addr(dreq_addr),
        .dreq_wen(dreq_wen), .dreq_wdata(dreq_wdata),
        .dresp_valid(dresp_valid), .dresp_rdata(dresp_rdata),
        .m_req_valid(m_req_valid), .m_req_ready(m_req_ready), .m_req_addr(m_req_addr),
        .m_req_wen(m_req_wen), .m_req_wdata(m_req_wdata),
        .m_resp_valid(m_resp_valid), .m_resp_rdata(m_resp_rdata),
        .t_req_valid(t_req_valid), .t_req_offset(t_req_offset),
        .t_req_wen(t_req_wen), .t_req_wdata(t_req_wdata),
        .t_resp_valid(t_resp_valid), .t_resp_rdata(t_resp_rdata)
    );

    bus_arbiter arb0 (
        .clk_in(clk_in), .rst_n(rst_n),
        .ireq_valid(ireq_valid), .ireq_ready(ireq_ready), .ireq_addr(ireq_addr),
        .iresp_valid(iresp_valid), .iresp_rdata(iresp_rdata),
        .dreq_valid(m_req_valid), .dreq_ready(m_req_ready), .dreq_addr(m_req_addr),
        .dreq_wen(m_req_wen), .dreq_wdata(m_req_wdata),
        .dresp_valid(m_resp_valid), .dresp_rdata(m_resp_rdata),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_req_addr(mem_req_addr), .mem_req_wen(mem_req_wen),
        .mem_req_wdata(mem_req_wdata),
        .mem_resp_valid(mem_resp_valid), .mem_resp_rdata(mem_resp_rdata)
    );

    main_memory #(
        .MEM_WORDS_LOG2(MEM_WORDS_LOG2)
    ) mem0 (
        .clk_in(clk_in), .rst_n(rst_n),
        .req_valid(mem_req_valid), .req_ready(mem_req_ready), .req_addr(mem_req_addr),
        .req_wen(mem_req_wen), .req_wdata(mem_req_wdata),
        .resp_valid(mem_resp_valid), .resp_rdata(mem_resp_rdata)
    );

    timer_regs #(
        .CLK_MHZ(CLK_MHZ)
    ) timer0 (
        .clk_in(clk_in), .rst_n(rst_n),
        .req_valid(t_req_valid), .req_offset(t_req_offset),
        .req_wen(t_req_wen), .req_wdata(t_req_wdata),
        .resp_valid(t_resp_valid), .resp_rdata(t_resp_rdata),
        .timer_irq(timer_irq), .exit(exit), .exit_code(exit_code)
    );

endmodule

`default_nettype wire

//--- include/tb_util.svh
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// ############################################################################
// bench state
// ############################################################################

int unsigned    err_count     = 0;
int unsigned    timeout_count = 0;
logic [31:0]    rng_state     = 32'd95;

// word model of main memory, keyed by aligned byte address.
soc_pkg::data_t model_mem [soc_pkg::addr_t];
soc_pkg::data_t last_exit_code = '0;
bit             exit_written   = 1'b0;

// ############################################################################
// random numbers and checks
// ############################################################################

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] rand_next();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

task automatic check(input string msg, input logic [31:0] actual,
                     input logic [31:0] expected);
    if (actual !== expected) begin
        $display("FAIL %0t: %s got %h expected %h", $time, msg, actual, expected);
        err_count++;
    end
endtask

task automatic note_timeout(input string what);
    $display("FAIL %0t: %s no response before timeout", $time, what);
    timeout_count++;
endtask

// ############################################################################
// memory model
// ############################################################################

// small window of 32 words so writes get read back.
function automatic soc_pkg::addr_t rand_mem_addr();
    logic [31:0] r;
    r = rand_next();
    return {25'd0, r[4:0], 2'b00};
endfunction

function automatic soc_pkg::data_t model_read(input soc_pkg::addr_t addr);
    soc_pkg::addr_t key;
    key = {addr[31:2], 2'b00};
    if (model_mem.exists(key)) begin
        return model_mem[key];
    end
    return '0;
endfunction

function automatic void model_write(input soc_pkg::addr_t addr, input soc_pkg::data_t data);
    model_mem[{addr[31:2], 2'b00}] = data;
endfunction

// only the first exit write counts.
function automatic void model_exit(input soc_pkg::data_t data);
    if (!exit_written) begin
        exit_written   = 1'b1;
        last_exit_code = data;
    end
endfunction

`endif

//--- bench/tb_mem_sys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_sys;

    localparam int MEM_WORDS_LOG2 = 10;
    localparam int CLK_MHZ        = 4;

    localparam soc_pkg::addr_t A_MCYCLE_LO   = soc_pkg::MMIO_BASE | 32'h00;
    localparam soc_pkg::addr_t A_MTIME_LO    = soc_pkg::MMIO_BASE | 32'h08;
    localparam soc_pkg::addr_t A_MTIMECMP_LO = soc_pkg::MMIO_BASE | 32'h10;
    localparam soc_pkg::addr_t A_MTIMECMP_HI = soc_pkg::MMIO_BASE | 32'h14;
    localparam soc_pkg::addr_t A_EXIT        = soc_pkg::MMIO_BASE | 32'h18;

    logic           clk_in;
    logic           rst_n;
    logic           ireq_valid;
    logic           ireq_ready;
    soc_pkg::addr_t ireq_addr;
    logic           iresp_valid;
    soc_pkg::data_t iresp_rdata;
    logic           dreq_valid;
    logic           dreq_ready;
    soc_pkg::addr_t dreq_addr;
    logic           dreq_wen;
    soc_pkg::data_t dreq_wdata;
    logic           dresp_valid;
    soc_pkg::data_t dresp_rdata;
    logic           timer_irq;
    logic           exit;
    soc_pkg::data_t exit_code;

    `include "tb_util.svh"

    mem_sys_top #(
        .MEM_WORDS_LOG2(MEM_WORDS_LOG2),
        .CLK_MHZ(CLK_MHZ)
    ) dut0 (
        .clk_in(clk_in), .rst_n(rst_n),
        .ireq_valid(ireq_valid), .ireq_ready(ireq_ready), .ireq_addr(ireq_addr),
        .iresp_valid(iresp_valid), .iresp_rdata(iresp_rdata),
        .dreq_valid(dreq_valid), .dreq_ready(dreq_ready), .dreq_addr(dreq_addr),
        .dreq_wen(dreq_wen), .dreq_wdata(dreq_wdata),
        .dresp_valid(dresp_valid), .dresp_rdata(dresp_rdata),
        .timer_irq(timer_irq), .exit(exit), .exit_code(exit_code)
    );

    always #4 clk_in = ~clk_in;

    // one data access, sampled 1 ns after each falling edge.
    task automatic data_access(input soc_pkg::addr_t addr, input logic wen,
                               input soc_pkg::data_t wdata, output soc_pkg::data_t rdata);
        int n;
        @(negedge clk_in);
        dreq_valid = 1'b1;
        dreq_addr  = addr;
        dreq_wen   = wen;
        dreq_wdata = wdata;
        n = 0;
        #1;
        while (!dreq_ready && n < 20) begin
            @(negedge clk_in);
            #1;
            n++;
        end
        if (!dreq_ready) begin
            note_timeout("data request");
        end
        @(negedge clk_in);
        dreq_valid = 1'b0;
        n = 0;
        #1;
        while (!dresp_valid && n < 20) begin
            @(negedge clk_in);
            #1;
            n++;
        end
        if (!dresp_valid) begin
            note_timeout("data response");
        end
        check("data response latency", n, 0);
        rdata = dresp_rdata;
    endtask

    initial begin
        soc_pkg::data_t      rd;
        soc_pkg::data_t      t0;
        soc_pkg::data_t      t1;
        soc_pkg::data_t      mc0;
        soc_pkg::data_t      mc1;
        soc_pkg::data_t      code;
        soc_pkg::data_t      d_exp;
        soc_pkg::data_t      i_exp;
        soc_pkg::bus_owner_e owner;
        logic [31:0]         r;
        bit                  d_hold;
        bit                  d_resp;
        bit                  i_hold;
        bit                  i_resp;
        int                  d_wait;
        int                  i_wait;
        int                  d_count;
        int                  i_count;
        int                  cycles;
        int                  n;

        clk_in     = 1'b0;
        rst_n      = 1'b0;
        ireq_valid = 1'b0;
        ireq_addr  = '0;
        dreq_valid = 1'b0;
        dreq_addr  = '0;
        dreq_wen   = 1'b0;
        dreq_wdata = '0;
        repeat (3) @(posedge clk_in);
        @(negedge clk_in);
        rst_n = 1'b1;

        check("timer_irq after reset", timer_irq, 0);
        check("exit after reset", exit, 0);
        check("exit_code after reset", exit_code, 0);

        // ####################################################################
        // timer registers
        // ####################################################################

        data_access(A_MCYCLE_LO, 1'b0, '0, mc0);
        data_access(A_MTIME_LO, 1'b0, '0, t0);
        repeat (40) @(negedge clk_in);
        data_access(A_MCYCLE_LO, 1'b0, '0, mc1);
        data_access(A_MTIME_LO, 1'b0, '0, t1);
        check("mtime advances over idle gap", (t1 - t0) >= (40 / CLK_MHZ - 1), 1);
        check("mcycle faster than mtime", (mc1 - mc0) > (t1 - t0), 1);
        for (int k = 0; k < 5; k++) begin
            data_access(A_MTIME_LO, 1'b0, '0, rd);
            check("mtime never decreases", rd >= t1, 1);
            t1 = rd;
        end

        // nonzero high half keeps the compare far above mtime.
        code = rand_next();
        data_access(A_MTIMECMP_LO, 1'b1, code, rd);
        check("write ack rdata", rd, 0);
        data_access(A_MTIMECMP_LO, 1'b0, '0, rd);
        check("mtimecmp lo readback", rd, code);
        code = rand_next() | 32'h1;
        data_access(A_MTIMECMP_HI, 1'b1, code, rd);
        data_access(A_MTIMECMP_HI, 1'b0, '0, rd);
        check("mtimecmp hi readback", rd, code);

        data_access(A_MTIMECMP_LO, 1'b1, '1, rd);
        data_access(A_MTIMECMP_HI, 1'b1, '1, rd);
        repeat (10) begin
            @(negedge clk_in);
            check("timer_irq with mtimecmp all ones", timer_irq, 0);
        end
        data_access(A_MTIMECMP_LO, 1'b1, '0, rd);
        data_access(A_MTIMECMP_HI, 1'b1, '0, rd);
        n = 0;
        while (!timer_irq && n < 2) begin
            @(negedge clk_in);
            n++;
        end
        check("timer_irq after mtimecmp cleared", timer_irq, 1);

        // ####################################################################
        // exit register
        // ####################################################################

        code = rand_next();
        data_access(A_EXIT, 1'b1, code, rd);
        model_exit(code);
        n = 0;
        while (!exit && n < 2) begin
            @(negedge clk_in);
            n++;
        end
        check("exit raised", exit, 1);
        check("exit_code", exit_code, last_exit_code);
        data_access(A_EXIT, 1'b1, ~code, rd);
        model_exit(~code);
        repeat (2) @(negedge clk_in);
        check("exit_code after second write", exit_code, last_exit_code);

        // ####################################################################
        // random traffic on both ports
        // ####################################################################

        d_hold  = 0;
        d_resp  = 0;
        i_hold  = 0;
        i_resp  = 0;
        d_wait  = 0;
        i_wait  = 0;
        d_count = 0;
        i_count = 0;
        cycles  = 0;
        d_exp   = '0;
        i_exp   = '0;
        while ((d_count < 300 || d_hold || d_resp || i_hold || i_resp) && cycles < 4000) begin
            @(negedge clk_in);
            cycles++;
            if (d_resp || (d_hold && d_wait > 20)) begin
                if (!d_resp) begin
                    note_timeout("random data request");
                end
                dreq_valid = 1'b0;
                d_hold     = 0;
            end
            if (i_resp || (i_hold && i_wait > 20)) begin
                if (!i_resp) begin
                    note_timeout("random instruction request");
                end
                ireq_valid = 1'b0;
                i_hold     = 0;
            end
            r = rand_next();
            if (!d_hold && !d_resp && d_count < 300 && r[2]) begin
                dreq_valid = 1'b1;
                dreq_addr  = rand_mem_addr();
                dreq_wen   = r[0];
                dreq_wdata = rand_next();
                d_hold     = 1;
                d_wait     = 0;
            end
            if (!i_hold && !i_resp && d_count < 300 && r[7]) begin
                ireq_valid = 1'b1;
                ireq_addr  = rand_mem_addr();
                i_hold     = 1;
                i_wait     = 0;
            end
            #1;
            owner = d_resp ? soc_pkg::OWN_DATA : (i_resp ? soc_pkg::OWN_INST : soc_pkg::OWN_IDLE);
            if (d_resp) begin
                check("dresp_valid one cycle after accept", dresp_valid, 1);
                check("data rdata", dresp_rdata, d_exp);
                check("dreq_ready in data response cycle", dreq_ready, 0);
                check("ireq_ready in data response cycle", ireq_ready, 0);
            end else begin
                check("dresp_valid without request", dresp_valid, 0);
            end
            if (i_resp) begin
                check("iresp_valid one cycle after accept", iresp_valid, 1);
                check("inst rdata", iresp_rdata, i_exp);
                check("ireq_ready in inst response cycle", ireq_ready, 0);
                check("dreq_ready in inst response cycle", dreq_ready, 0);
            end else begin
                check("iresp_valid without request", iresp_valid, 0);
            end
            if (dreq_valid && owner == soc_pkg::OWN_IDLE) begin
                check("ireq_ready while data valid", ireq_ready, 0);
            end
            check("both ports accepted together",
                  (d_hold && dreq_ready) && (i_hold && ireq_ready), 0);
            d_resp = 0;
            i_resp = 0;
            if (d_hold && dreq_ready) begin
                d_exp = dreq_wen ? '0 : model_read(dreq_addr);
                if (dreq_wen) begin
                    model_write(dreq_addr, dreq_wdata);
                end
                d_resp = 1;
                d_count++;
            end else if (d_hold) begin
                d_wait++;
            end
            if (i_hold && ireq_ready) begin
                i_exp  = model_read(ireq_addr);
                i_resp = 1;
                i_count++;
            end else if (i_hold) begin
                i_wait++;
            end
        end
        @(negedge clk_in);
        dreq_valid = 1'b0;
        ireq_valid = 1'b0;
        check("all data transactions done", d_count >= 300, 1);
        check("instruction traffic seen", i_count > 0, 1);

        $display("errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_sys_top.f
+incdir+include
design/soc_pkg.sv
design/main_memory.sv
design/bus_arbiter.sv
design/mmio_router.sv
design/timer_regs.sv
design/mem_sys_top.sv
bench/tb_mem_sys.sv
